// ==== common/qpu_exu_pkg.sv ====
`default_nettype none

package qpu_exu_pkg;

  //////////////////////////////
  // widths and depths
  //////////////////////////////
  localparam int XLEN       = 32;
  localparam int RF_NUM     = 8;
  localparam int RFIDX_W    = 3;
  localparam int QUBIT_NUM  = 8;
  localparam int TIME_W     = 16;
  localparam int OITF_DEPTH = 4;

  // oitf pointer and occupancy widths
  localparam int OITF_PTR_W = $clog2(OITF_DEPTH);
  localparam int OITF_CNT_W = OITF_PTR_W + 1;

  //////////////////////////////
  // decoded operation
  //////////////////////////////
  typedef enum logic [2:0] {
    OP_NOP     = 3'd0,
    OP_ADDI    = 3'd1,
    OP_ADD     = 3'd2,
    OP_QWAIT   = 3'd3,
    OP_MEASURE = 3'd4,
    OP_FMR     = 3'd5
  } op_kind_e;

  // imm low bits carry the qubit list or the wait count
  typedef struct packed {
    op_kind_e            kind;
    logic [RFIDX_W-1:0]  rd;
    logic [RFIDX_W-1:0]  rs1;
    logic [RFIDX_W-1:0]  rs2;
    logic [XLEN-1:0]     imm;
  } exu_op_t;

  //////////////////////////////
  // write-back and measurement
  //////////////////////////////
  typedef struct packed {
    logic                valid;
    logic [RFIDX_W-1:0]  rdidx;
    logic [XLEN-1:0]     data;
  } wbck_t;

  typedef struct packed {
    logic                 valid;
    logic [QUBIT_NUM-1:0] qlist;
  } meas_req_t;

  // one result bit per qubit
  typedef struct packed {
    logic                 valid;
    logic [QUBIT_NUM-1:0] data;
  } mcu_result_t;

endpackage

`default_nettype wire

// ==== design/qpu_wait_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module qpu_wait_timer
  import qpu_exu_pkg::*;
(
  input  logic              clk,
  input  logic              i_rst,
  input  logic              i_start,
  input  logic [TIME_W-1:0] i_count,
  output logic              o_expire
);

  // remaining cycles, zero when idle
  logic [TIME_W-1:0] cnt;

  always_ff @(posedge clk)
  begin
    if (i_rst)
      cnt <= '0;
    else if (i_start)
      cnt <= (i_count == '0) ? TIME_W'(1) : i_count;
    else if (cnt != '0)
      cnt <= cnt - TIME_W'(1);
  end

  // last counted cycle
  assign o_expire = (cnt == TIME_W'(1));

endmodule

`default_nettype wire

// ==== design/qpu_classical_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module qpu_classical_regfile
  import qpu_exu_pkg::*;
(
  input  logic               clk,
  input  logic               i_rst,
  input  logic [RFIDX_W-1:0] i_rs1_idx,
  input  logic [RFIDX_W-1:0] i_rs2_idx,
  input  wbck_t              i_wr,
  output logic [XLEN-1:0]    o_rs1_data,
  output logic [XLEN-1:0]    o_rs2_data
);

  logic [XLEN-1:0] regs [RF_NUM];

  // r0 is never written
  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      for (int i = 0; i < RF_NUM; i++)
        regs[i] <= '0;
    end
    else if (i_wr.valid && (i_wr.rdidx != '0))
    begin
      regs[i_wr.rdidx] <= i_wr.data;
    end
  end

  // combinational reads, r0 hardwired to zero
  always_comb
  begin
    o_rs1_data = (i_rs1_idx == '0) ? '0 : regs[i_rs1_idx];
    o_rs2_data = (i_rs2_idx == '0) ? '0 : regs[i_rs2_idx];
  end

endmodule

`default_nettype wire

// ==== meas/qpu_meas_oitf.sv ====
`timescale 1ns/10ps
`default_nettype none

module qpu_meas_oitf
  import qpu_exu_pkg::*;
(
  input  logic                 clk,
  input  logic                 i_rst,
  input  logic                 i_push,
  input  logic [QUBIT_NUM-1:0] i_push_qlist,
  input  logic [QUBIT_NUM-1:0] i_qlist,
  input  mcu_result_t          i_mcu,
  output logic                 o_qlist_conflict,
  output logic                 o_full,
  output logic [QUBIT_NUM-1:0] o_head_qlist
);

  logic [QUBIT_NUM-1:0]  entries [OITF_DEPTH];
  logic [OITF_PTR_W-1:0] wptr;
  logic [OITF_PTR_W-1:0] rptr;
  logic [OITF_CNT_W-1:0] count;
  logic                  push;
  logic                  pop;
  logic [OITF_PTR_W-1:0] offset;
  logic [QUBIT_NUM-1:0]  busy_mask;

  assign o_full = (count == OITF_CNT_W'(OITF_DEPTH));
  assign push   = i_push && !o_full;
  // results with nothing outstanding are dropped
  assign pop    = i_mcu.valid && (count != '0);

  //////////////////////////////
  // queue storage and pointers
  //////////////////////////////
  always_ff @(posedge clk)
  begin
    if (push)
      entries[wptr] <= i_push_qlist;
  end

  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wptr <= wptr + OITF_PTR_W'(1);
      if (pop)
        rptr <= rptr + OITF_PTR_W'(1);
      case ({push, pop})
        2'b10:   count <= count + OITF_CNT_W'(1);
        2'b01:   count <= count - OITF_CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  //////////////////////////////
  // busy mask over live entries
  //////////////////////////////
  always_comb
  begin
    busy_mask = '0;
    offset    = '0;
    for (int i = 0; i < OITF_DEPTH; i++)
    begin
      // distance from the head decides whether slot i is live
      offset = OITF_PTR_W'(i) - rptr;
      if ({1'b0, offset} < count)
        busy_mask = busy_mask | entries[i];
    end
  end

  assign o_qlist_conflict = |(i_qlist & busy_mask);

  // zero mask when empty so stray results change nothing
  assign o_head_qlist = (count != '0) ? entries[rptr] : '0;

endmodule

`default_nettype wire

// ==== meas/qpu_meas_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module qpu_meas_regfile
  import qpu_exu_pkg::*;
(
  input  logic                 clk,
  input  logic                 i_rst,
  input  mcu_result_t          i_mcu,
  input  logic [QUBIT_NUM-1:0] i_head_qlist,
  output logic [QUBIT_NUM-1:0] o_meas_data
);

  // one stored result bit per qubit
  logic [QUBIT_NUM-1:0] meas_bits;
  logic [QUBIT_NUM-1:0] meas_next;

  // merge new data only where the retired list points
  assign meas_next = (meas_bits & ~i_head_qlist) | (i_mcu.data & i_head_qlist);

  always_ff @(posedge clk)
  begin
    if (i_rst)
      meas_bits <= '0;
    else if (i_mcu.valid)
      meas_bits <= meas_next;
  end

  // masking by the fmr list happens in the controller
  assign o_meas_data = meas_bits;

endmodule

`default_nettype wire

// ==== design/qpu_exu_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module qpu_exu_ctrl
  import qpu_exu_pkg::*;
(
  input  logic                 clk,
  input  logic                 i_rst,
  input  logic                 i_op_valid,
  input  exu_op_t              i_op,
  input  logic [XLEN-1:0]      i_rs1_data,
  input  logic [XLEN-1:0]      i_rs2_data,
  input  logic [QUBIT_NUM-1:0] i_meas_data,
  input  logic                 i_qlist_conflict,
  input  logic                 i_oitf_full,
  input  logic                 i_expire,
  output logic                 o_ready,
  output logic [RFIDX_W-1:0]   o_rs1_idx,
  output logic [RFIDX_W-1:0]   o_rs2_idx,
  output wbck_t                o_rf_wr,
  output wbck_t                o_wb,
  output meas_req_t            o_meas_req,
  output logic                 o_push,
  output logic [QUBIT_NUM-1:0] o_qlist,
  output logic                 o_timer_start,
  output logic [TIME_W-1:0]    o_timer_count,
  output logic                 o_timepoint
);

  typedef enum logic {
    ST_ISSUE = 1'b0,
    ST_WAIT  = 1'b1
  } state_e;

  state_e          state;
  logic            accept;
  logic            is_wb_op;
  logic [XLEN-1:0] alu_data;

  //////////////////////////////
  // issue and stall
  //////////////////////////////
  assign o_qlist   = i_op.imm[QUBIT_NUM-1:0];
  assign o_rs1_idx = i_op.rs1;
  assign o_rs2_idx = i_op.rs2;

  // fmr waits on pending measurements, measure on a free slot
  assign o_ready = (state == ST_ISSUE) &&
                   !((i_op.kind == OP_FMR) && i_qlist_conflict) &&
                   !((i_op.kind == OP_MEASURE) && i_oitf_full);

  assign accept = i_op_valid && o_ready;

  assign o_push        = accept && (i_op.kind == OP_MEASURE);
  assign o_timer_start = accept && (i_op.kind == OP_QWAIT);
  assign o_timer_count = i_op.imm[TIME_W-1:0];

  always_ff @(posedge clk)
  begin
    if (i_rst)
      state <= ST_ISSUE;
    else if (state == ST_ISSUE && o_timer_start)
      state <= ST_WAIT;
    else if (state == ST_WAIT && i_expire)
      state <= ST_ISSUE;
  end

  //////////////////////////////
  // classical arithmetic
  //////////////////////////////
  always_comb
  begin
    is_wb_op = 1'b0;
    alu_data = '0;
    case (i_op.kind)
      OP_ADDI:
      begin
        is_wb_op = 1'b1;
        alu_data = i_rs1_data + i_op.imm;
      end
      OP_ADD:
      begin
        is_wb_op = 1'b1;
        alu_data = i_rs1_data + i_rs2_data;
      end
      OP_FMR:
      begin
        is_wb_op = 1'b1;
        // only the requested qubits, rest zero
        alu_data = XLEN'(i_meas_data & o_qlist);
      end
      default:
      begin
        is_wb_op = 1'b0;
      end
    endcase
  end

  // written at the accepting edge
  assign o_rf_wr.valid = accept && is_wb_op;
  assign o_rf_wr.rdidx = i_op.rd;
  assign o_rf_wr.data  = alu_data;

  //////////////////////////////
  // registered outputs
  //////////////////////////////
  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      o_wb        <= '0;
      o_meas_req  <= '0;
      o_timepoint <= 1'b0;
    end
    else
    begin
      o_wb             <= o_rf_wr;
      o_meas_req.valid <= o_push;
      o_meas_req.qlist <= o_qlist;
      // first ready cycle after the wait
      o_timepoint      <= (state == ST_WAIT) && i_expire;
    end
  end

endmodule

`default_nettype wire

// ==== design/qpu_exu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module qpu_exu_top
  import qpu_exu_pkg::*;
(
  input  logic        clk,
  input  logic        i_rst,
  input  logic        i_op_valid,
  input  exu_op_t     i_op,
  input  mcu_result_t i_mcu,
  output logic        o_ready,
  output wbck_t       o_wb,
  output meas_req_t   o_meas_req,
  output logic        o_timepoint
);

  // register file ports
  logic [RFIDX_W-1:0]   rs1_idx;
  logic [RFIDX_W-1:0]   rs2_idx;
  logic [XLEN-1:0]      rs1_data;
  logic [XLEN-1:0]      rs2_data;
  wbck_t                rf_wr;

  // measurement side
  logic                 oitf_push;
  logic [QUBIT_NUM-1:0] cand_qlist;
  logic                 qlist_conflict;
  logic                 oitf_full;
  logic [QUBIT_NUM-1:0] head_qlist;
  logic [QUBIT_NUM-1:0] meas_data;

  // qwait timer
  logic                 timer_start;
  logic [TIME_W-1:0]    timer_count;
  logic                 timer_expire;

  qpu_exu_ctrl u_ctrl (
    .clk              (clk),
    .i_rst            (i_rst),
    .i_op_valid       (i_op_valid),
    .i_op             (i_op),
    .i_rs1_data       (rs1_data),
    .i_rs2_data       (rs2_data),
    .i_meas_data      (meas_data),
    .i_qlist_conflict (qlist_conflict),
    .i_oitf_full      (oitf_full),
    .i_expire         (timer_expire),
    .o_ready          (o_ready),
    .o_rs1_idx        (rs1_idx),
    .o_rs2_idx        (rs2_idx),
    .o_rf_wr          (rf_wr),
    .o_wb             (o_wb),
    .o_meas_req       (o_meas_req),
    .o_push           (oitf_push),
    .o_qlist          (cand_qlist),
    .o_timer_start    (timer_start),
    .o_timer_count    (timer_count),
    .o_timepoint      (o_timepoint)
  );

  qpu_wait_timer u_wait_timer (
    .clk      (clk),
    .i_rst    (i_rst),
    .i_start  (timer_start),
    .i_count  (timer_count),
    .o_expire (timer_expire)
  );

  qpu_classical_regfile u_crf (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_rs1_idx  (rs1_idx),
    .i_rs2_idx  (rs2_idx),
    .i_wr       (rf_wr),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  qpu_meas_oitf u_meas_oitf (
    .clk              (clk),
    .i_rst            (i_rst),
    .i_push           (oitf_push),
    .i_push_qlist     (cand_qlist),
    .i_qlist          (cand_qlist),
    .i_mcu            (i_mcu),
    .o_qlist_conflict (qlist_conflict),
    .o_full           (oitf_full),
    .o_head_qlist     (head_qlist)
  );

  qpu_meas_regfile u_meas_rf (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_mcu        (i_mcu),
    .i_head_qlist (head_qlist),
    .o_meas_data  (meas_data)
  );

endmodule

`default_nettype wire

// ==== tb/tb_qpu_exu_tasks.svh ====
`ifndef TB_QPU_EXU_TASKS_SVH
`define TB_QPU_EXU_TASKS_SVH

//////////////////////////////
// helpers
//////////////////////////////
// xorshift32
function automatic logic [31:0] next_rand();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

function automatic void report_mismatch(input string name, input logic [XLEN-1:0] expv,
                                        input logic [XLEN-1:0] actv);
  err_count++;
  $display("MISMATCH %s expected 0x%h actual 0x%h at %0t", name, expv, actv, $time);
endfunction

function automatic void report_failure(input string what);
  err_count++;
  $display("ERROR %s at %0t", what, $time);
endfunction

function automatic exu_op_t make_op(input op_kind_e kind, input logic [RFIDX_W-1:0] rd,
                                    input logic [RFIDX_W-1:0] rs1,
                                    input logic [RFIDX_W-1:0] rs2,
                                    input logic [XLEN-1:0] imm);
  exu_op_t op;
  op.kind = kind;
  op.rd   = rd;
  op.rs1  = rs1;
  op.rs2  = rs2;
  op.imm  = imm;
  return op;
endfunction

task automatic idle(input int cycles);
  repeat (cycles) @(posedge clk);
  #1;
endtask

// hold the operation until accepted, count the stalled cycles
task automatic issue_op(input exu_op_t op, output int stalls);
  stalls     = 0;
  i_op_valid = 1'b1;
  i_op       = op;
  @(negedge clk);
  while (!o_ready && stalls < STALL_LIMIT)
  begin
    stalls++;
    @(negedge clk);
  end
  if (!o_ready)
    report_failure("operation was not accepted within the stall limit");
  @(posedge clk);
  #1;
  op_count++;
  i_op_valid = 1'b0;
  i_op       = '0;
endtask

// op must stall until one result retires the oldest list
task automatic stall_then_retire(input exu_op_t op, input logic [QUBIT_NUM-1:0] data,
                                 input int hold);
  int n;
  i_op_valid = 1'b1;
  i_op       = op;
  for (n = 0; n < hold; n++)
  begin
    @(negedge clk);
    if (o_ready !== 1'b0)
      report_mismatch("o_ready", XLEN'(0), XLEN'(o_ready));
    @(posedge clk);
    #1;
  end
  i_mcu = '{valid: 1'b1, data: data};
  @(negedge clk);
  if (o_ready !== 1'b0)
    report_mismatch("o_ready", XLEN'(0), XLEN'(o_ready));
  @(posedge clk);
  #1;
  i_mcu = '0;
  @(negedge clk);
  if (o_ready !== 1'b1)
    report_mismatch("o_ready", XLEN'(1), XLEN'(o_ready));
  @(posedge clk);
  #1;
  op_count++;
  i_op_valid = 1'b0;
  i_op       = '0;
endtask

//////////////////////////////
// reference model
//////////////////////////////
task automatic compare_outputs();
  if (o_wb.valid !== exp_wb.valid)
    report_mismatch("o_wb.valid", XLEN'(exp_wb.valid), XLEN'(o_wb.valid));
  if (exp_wb.valid && o_wb.rdidx !== exp_wb.rdidx)
    report_mismatch("o_wb.rdidx", XLEN'(exp_wb.rdidx), XLEN'(o_wb.rdidx));
  if (exp_wb.valid && o_wb.data !== exp_wb.data)
    report_mismatch("o_wb.data", exp_wb.data, o_wb.data);
  if (o_meas_req.valid !== exp_meas.valid)
    report_mismatch("o_meas_req.valid", XLEN'(exp_meas.valid), XLEN'(o_meas_req.valid));
  if (exp_meas.valid && o_meas_req.qlist !== exp_meas.qlist)
    report_mismatch("o_meas_req.qlist", XLEN'(exp_meas.qlist), XLEN'(o_meas_req.qlist));
endtask

// outputs expected one cycle after the accepting edge
task automatic predict_next();
  logic [XLEN-1:0]      rs1_val;
  logic [XLEN-1:0]      rs2_val;
  logic [QUBIT_NUM-1:0] op_qlist;
  logic [QUBIT_NUM-1:0] head;
  exp_wb   = '0;
  exp_meas = '0;
  op_qlist = i_op.imm[QUBIT_NUM-1:0];
  rs1_val  = model_regs[i_op.rs1];
  rs2_val  = model_regs[i_op.rs2];
  if (i_op_valid && o_ready)
  begin
    case (i_op.kind)
      OP_ADDI:    exp_wb = '{valid: 1'b1, rdidx: i_op.rd, data: rs1_val + i_op.imm};
      OP_ADD:     exp_wb = '{valid: 1'b1, rdidx: i_op.rd, data: rs1_val + rs2_val};
      OP_FMR:     exp_wb = '{valid: 1'b1, rdidx: i_op.rd, data: XLEN'(model_meas & op_qlist)};
      OP_MEASURE: exp_meas = '{valid: 1'b1, qlist: op_qlist};
      default:    exp_wb = '0;
    endcase
    // r0 writes are reported, never stored
    if (exp_wb.valid && exp_wb.rdidx != '0)
      model_regs[exp_wb.rdidx] = exp_wb.data;
  end
  // retire before this cycle's push
  if (i_mcu.valid && model_q.size() != 0)
  begin
    head       = model_q.pop_front();
    model_meas = (model_meas & ~head) | (i_mcu.data & head);
  end
  if (exp_meas.valid)
    model_q.push_back(exp_meas.qlist);
endtask

//////////////////////////////
// directed tests
//////////////////////////////
task automatic check_reset_state();
  @(negedge clk);
  if (o_ready !== 1'b1)
    report_mismatch("o_ready", XLEN'(1), XLEN'(o_ready));
  if (o_wb.valid !== 1'b0)
    report_mismatch("o_wb.valid", XLEN'(0), XLEN'(o_wb.valid));
  if (o_meas_req.valid !== 1'b0)
    report_mismatch("o_meas_req.valid", XLEN'(0), XLEN'(o_meas_req.valid));
  if (o_timepoint !== 1'b0)
    report_mismatch("o_timepoint", XLEN'(0), XLEN'(o_timepoint));
  @(posedge clk);
  #1;
endtask

task automatic test_classical();
  int          stalls;
  int          i;
  logic [31:0] r;
  op_kind_e    kind;
  issue_op(make_op(OP_ADDI, 3'd1, 3'd0, 3'd0, next_rand()), stalls);
  // back to back, each reads the previous result
  issue_op(make_op(OP_ADDI, 3'd2, 3'd1, 3'd0, next_rand()), stalls);
  issue_op(make_op(OP_ADD, 3'd3, 3'd1, 3'd2, '0), stalls);
  issue_op(make_op(OP_ADD, 3'd4, 3'd3, 3'd3, '0), stalls);
  issue_op(make_op(OP_ADDI, 3'd0, 3'd4, 3'd0, next_rand()), stalls);
  issue_op(make_op(OP_ADD, 3'd5, 3'd0, 3'd4, '0), stalls);
  issue_op(make_op(OP_ADD, 3'd6, 3'd0, 3'd0, '0), stalls);
  for (i = 0; i < 12; i++)
  begin
    r    = next_rand();
    kind = r[0] ? OP_ADD : OP_ADDI;
    issue_op(make_op(kind, r[3:1], r[6:4], r[9:7], next_rand()), stalls);
  end
  idle(2);
endtask

task automatic test_qwait(input logic [TIME_W-1:0] count);
  int stalls;
  int low_cycles;
  int expected;
  expected   = (count == '0) ? 1 : int'(count);
  low_cycles = 0;
  issue_op(make_op(OP_QWAIT, 3'd0, 3'd0, 3'd0, XLEN'(count)), stalls);
  @(negedge clk);
  while (!o_ready && low_cycles < STALL_LIMIT)
  begin
    if (o_timepoint !== 1'b0)
      report_mismatch("o_timepoint", XLEN'(0), XLEN'(o_timepoint));
    low_cycles++;
    @(negedge clk);
  end
  if (low_cycles != expected)
    report_mismatch("o_ready low cycles", XLEN'(expected), XLEN'(low_cycles));
  // single pulse in the first ready cycle
  if (o_timepoint !== 1'b1)
    report_mismatch("o_timepoint", XLEN'(1), XLEN'(o_timepoint));
  @(negedge clk);
  if (o_timepoint !== 1'b0)
    report_mismatch("o_timepoint", XLEN'(0), XLEN'(o_timepoint));
  @(posedge clk);
  #1;
endtask

task automatic test_measure_fmr();
  int stalls;
  issue_op(make_op(OP_MEASURE, 3'd0, 3'd0, 3'd0, XLEN'(8'h0f)), stalls);
  stall_then_retire(make_op(OP_FMR, 3'd7, 3'd0, 3'd0, XLEN'(8'h01)),
                    QUBIT_NUM'(next_rand()), 3);
  issue_op(make_op(OP_MEASURE, 3'd0, 3'd0, 3'd0, XLEN'(8'h06)), stalls);
  stall_then_retire(make_op(OP_FMR, 3'd6, 3'd0, 3'd0, XLEN'(8'h02)),
                    QUBIT_NUM'(next_rand()), 3);
  // wide read, bits 0 and 3 from the first result
  issue_op(make_op(OP_FMR, 3'd5, 3'd0, 3'd0, XLEN'(8'hff)), stalls);
  if (stalls != 0)
    report_failure("fmr stalled with no measurement outstanding");
  idle(2);
endtask

task automatic test_oitf_full();
  logic [QUBIT_NUM-1:0] lists [5];
  int                   stalls;
  int                   i;
  for (i = 0; i < 5; i++)
    lists[i] = QUBIT_NUM'(1) << i;
  for (i = 0; i < OITF_DEPTH; i++)
    issue_op(make_op(OP_MEASURE, 3'd0, 3'd0, 3'd0, XLEN'(lists[i])), stalls);
  // fifth waits for the first retire
  stall_then_retire(make_op(OP_MEASURE, 3'd0, 3'd0, 3'd0, XLEN'(lists[4])),
                    QUBIT_NUM'(next_rand()), 3);
  issue_op(make_op(OP_FMR, 3'd1, 3'd0, 3'd0, XLEN'(lists[0])), stalls);
  if (stalls != 0)
    report_failure("fmr stalled on a list that was already retired");
  // each fmr clears only when its own list is the oldest
  for (i = 1; i < 5; i++)
    stall_then_retire(make_op(OP_FMR, RFIDX_W'(i + 1), 3'd0, 3'd0, XLEN'(lists[i])),
                      QUBIT_NUM'(next_rand()), 2);
  idle(2);
endtask

`endif

// ==== tb/tb_qpu_exu.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_qpu_exu
  import qpu_exu_pkg::*;
();

  localparam int CLK_PERIOD  = 4;
  localparam int RESET_CYCLES = 3;
  localparam int STALL_LIMIT = 100;
  // rough sum of the directed tests, plus margin for stalls
  localparam int TEST_CYCLES     = 600;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + 1400;

  logic        clk = 1'b0;
  logic        i_rst;
  logic        i_op_valid;
  exu_op_t     i_op;
  mcu_result_t i_mcu;
  logic        o_ready;
  wbck_t       o_wb;
  meas_req_t   o_meas_req;
  logic        o_timepoint;

  // reference model state
  logic [XLEN-1:0]      model_regs [RF_NUM];
  logic [QUBIT_NUM-1:0] model_meas;
  logic [QUBIT_NUM-1:0] model_q [$];
  wbck_t                exp_wb;
  meas_req_t            exp_meas;
  logic [31:0]          rng_state;
  int                   err_count;
  int                   op_count;

  qpu_exu_top dut_i (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_op_valid  (i_op_valid),
    .i_op        (i_op),
    .i_mcu       (i_mcu),
    .o_ready     (o_ready),
    .o_wb        (o_wb),
    .o_meas_req  (o_meas_req),
    .o_timepoint (o_timepoint)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  `include "tb_qpu_exu_tasks.svh"

  //////////////////////////////
  // output monitor
  //////////////////////////////
  // outputs settle well before the falling edge
  always @(negedge clk)
  begin
    if (i_rst === 1'b0)
    begin
      compare_outputs();
      predict_next();
    end
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog timeout, the run did not end within %0d cycles", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////
  initial
  begin
    rng_state  = 32'hcb9f;
    err_count  = 0;
    op_count   = 0;
    model_meas = '0;
    exp_wb     = '0;
    exp_meas   = '0;
    for (int i = 0; i < RF_NUM; i++)
      model_regs[i] = '0;
    i_rst      = 1'b1;
    i_op_valid = 1'b0;
    i_op       = '0;
    i_mcu      = '0;

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    i_rst = 1'b0;

    check_reset_state();
    test_classical();
    test_qwait(TIME_W'(0));
    test_qwait(TIME_W'(1));
    test_qwait(TIME_W'(next_rand() % 40) + TIME_W'(1));
    test_measure_fmr();
    test_oitf_full();
    idle(4);

    $display("%0d operations issued, %0d errors", op_count, err_count);
    if (err_count == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== qpu_exu.f ====
+incdir+tb
common/qpu_exu_pkg.sv
design/qpu_wait_timer.sv
design/qpu_classical_regfile.sv
meas/qpu_meas_oitf.sv
meas/qpu_meas_regfile.sv
design/qpu_exu_ctrl.sv
design/qpu_exu_top.sv
tb/tb_qpu_exu.sv

// ==== Makefile ====
# Verilator build for the execute stage testbench

TOP       ?= tb_qpu_exu
FILELIST  ?= qpu_exu.f
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= SIMULATION PASSED

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
